//--- rtl/decode_macros.svh
`ifndef DECODE_MACROS_SVH
`define DECODE_MACROS_SVH

////////////////////////////////////////////////////////////
// packet and datapath widths
////////////////////////////////////////////////////////////
`define PKT_BYTES  16
`define PKT_W      128          // 16 bytes, byte 0 in the top bits
`define EIP_W      32
`define LEN_W      4            // x86 lengths run 1..15
`define DISP_W     32
`define IMM_W      32

// bytes from just past the opcode (or ModRM) to the packet end
`define TAIL_BYTES 10

////////////////////////////////////////////////////////////
// legacy prefix bytes
////////////////////////////////////////////////////////////
`define MAX_PFX    3            // prefixes looked at before the opcode
`define PFX_REP    8'hF3
`define PFX_OPSIZE 8'h66

// segment overrides
`define PFX_ES     8'h26
`define PFX_CS     8'h2E
`define PFX_SS     8'h36
`define PFX_DS     8'h3E
`define PFX_FS     8'h64
`define PFX_GS     8'h65

`endif

//--- rtl/decode_pkg.sv
`include "decode_macros.svh"

package decode_pkg;

    typedef logic [`EIP_W-1:0] eip_t;
    typedef logic [`LEN_W-1:0] len_t;

    // segment override, none when no prefix seen
    typedef enum logic [2:0] {
        SEG_NONE, SEG_ES, SEG_CS, SEG_SS, SEG_DS, SEG_FS, SEG_GS
    } seg_e;

    // immediate size; IMM_WD is 2 or 4 bytes by operand size
    typedef enum logic [1:0] {
        IMM_NONE, IMM_BYTE, IMM_WD
    } imm_kind_e;

    typedef struct packed {
        logic [1:0] count;       // prefixes in front of the opcode
        logic       rep;
        logic       opsize;      // 66 seen
        seg_e       seg;         // last override wins
    } prefix_t;

    typedef struct packed {
        logic      two_byte;     // 0F escape
        logic      has_modrm;
        imm_kind_e imm_kind;
        logic      invalid;      // outside the supported subset
    } op_class_t;

    typedef struct packed {
        logic [1:0] mod;
        logic [2:0] reg_op;
        logic [2:0] rm;
        logic       has_sib;
        logic [1:0] scale;
        logic [2:0] index;
        logic [2:0] base;
        logic [2:0] disp_bytes;  // 0, 1 or 4
    } addr_t;

    // one decoded instruction as handed downstream
    typedef struct packed {
        prefix_t             pfx;
        logic [7:0]          opcode;  // byte after 0F for two-byte forms
        op_class_t           cls;
        addr_t               addr;
        logic [`DISP_W-1:0]  disp;
        logic [`IMM_W-1:0]   imm;
        len_t                len;
        eip_t                eip;
        eip_t                next_eip;
    } decoded_t;

endpackage

//--- rtl/prefix_decode.sv
`timescale 1ns/100ps
`include "decode_macros.svh"

module prefix_decode (
    input  logic [`MAX_PFX*8-1:0] pkt_head,  // packet bytes 0..2, byte 0 on top
    output decode_pkg::prefix_t   pfx,
    output logic [1:0]            op_index   // where the opcode starts
);
    import decode_pkg::*;

    logic [7:0] cur;    // byte being looked at
    logic       scan;   // still inside the prefix run

    ////////////////////////////////////////////////////////////
    // walk bytes in order, first non-prefix ends the run
    ////////////////////////////////////////////////////////////
    always_comb begin
        pfx  = '0;
        scan = 1'b1;
        cur  = '0;
        for (int i = 0; i < `MAX_PFX; i++) begin
            cur = pkt_head[(`MAX_PFX-1-i)*8 +: 8];
            if (scan) begin
                case (cur)
                    `PFX_REP:    pfx.rep    = 1'b1;
                    `PFX_OPSIZE: pfx.opsize = 1'b1;
                    `PFX_ES:     pfx.seg    = SEG_ES;
                    `PFX_CS:     pfx.seg    = SEG_CS;
                    `PFX_SS:     pfx.seg    = SEG_SS;
                    `PFX_DS:     pfx.seg    = SEG_DS;
                    `PFX_FS:     pfx.seg    = SEG_FS;
                    `PFX_GS:     pfx.seg    = SEG_GS;
                    default:     scan       = 1'b0;  // opcode reached
                endcase
                if (scan) begin
                    pfx.count = pfx.count + 2'd1;
                end
            end
        end
    end

    // three prefixes put the opcode at byte 3
    assign op_index = pfx.count;

endmodule

//--- rtl/opcode_class.sv
`timescale 1ns/100ps

module opcode_class (
    input  logic [15:0]           op_bytes,  // opcode on top, next byte below
    output decode_pkg::op_class_t cls
);
    import decode_pkg::*;

    logic [7:0] b0;  // first opcode byte
    logic [7:0] b1;  // byte after an 0F escape

    assign b0 = op_bytes[15:8];
    assign b1 = op_bytes[7:0];

    always_comb begin
        cls = '0;
        if (b0 == 8'h0F) begin
            cls.two_byte = 1'b1;
            casez (b1)
                8'b1000_????: cls.imm_kind  = IMM_WD;  // jcc rel32
                8'hAF:        cls.has_modrm = 1'b1;    // imul r, r/m
                default:      cls.invalid   = 1'b1;
            endcase
        end else begin
            casez (b0)
                8'h90, 8'hC3: ;                        // nop, ret
                8'h04:        cls.imm_kind = IMM_BYTE; // add al, ib
                8'h05:        cls.imm_kind = IMM_WD;   // add eax, id
                8'h01, 8'h03, 8'h89, 8'h8B: begin
                    cls.has_modrm = 1'b1;              // reg <-> r/m forms
                end
                8'h80, 8'h83: begin                    // group 1 with ib
                    cls.has_modrm = 1'b1;
                    cls.imm_kind  = IMM_BYTE;
                end
                8'h81: begin                           // group 1 with id
                    cls.has_modrm = 1'b1;
                    cls.imm_kind  = IMM_WD;
                end
                8'b1011_1???: cls.imm_kind = IMM_WD;   // mov r32, imm
                8'hE8, 8'hE9: cls.imm_kind = IMM_WD;   // call / jmp rel32
                8'hEB:        cls.imm_kind = IMM_BYTE; // jmp rel8
                default:      cls.invalid  = 1'b1;
            endcase
        end
    end

endmodule

//--- rtl/modrm_decode.sv
`timescale 1ns/100ps

module modrm_decode (
    input  logic [15:0]       modrm_bytes,  // ModRM on top, SIB candidate below
    input  logic              has_modrm,
    output decode_pkg::addr_t addr
);
    logic [7:0] modrm;
    logic [7:0] sib;
    logic       sib_here;     // rm=100 with a memory operand
    logic       no_base;      // mod 0 absolute form, disp32 only

    assign modrm = modrm_bytes[15:8];
    assign sib   = modrm_bytes[7:0];

    assign sib_here = (modrm[7:6] != 2'b11) && (modrm[2:0] == 3'b100);

    // mod 0 with rm=101, or SIB base=101, drops the base for a disp32
    assign no_base = (modrm[7:6] == 2'b00) &&
                     (sib_here ? (sib[2:0] == 3'b101) : (modrm[2:0] == 3'b101));

    ////////////////////////////////////////////////////////////
    // 32-bit addressing fields
    ////////////////////////////////////////////////////////////
    always_comb begin
        addr = '0;
        if (has_modrm) begin
            addr.mod     = modrm[7:6];
            addr.reg_op  = modrm[5:3];
            addr.rm      = modrm[2:0];
            addr.has_sib = sib_here;
            if (sib_here) begin
                addr.scale = sib[7:6];
                addr.index = sib[5:3];
                addr.base  = sib[2:0];
            end
            case (modrm[7:6])
                2'b00:   addr.disp_bytes = no_base ? 3'd4 : 3'd0;
                2'b01:   addr.disp_bytes = 3'd1;  // disp8
                2'b10:   addr.disp_bytes = 3'd4;  // disp32
                default: addr.disp_bytes = 3'd0;  // register operand
            endcase
        end
    end

endmodule

//--- rtl/disp_imm_extract.sv
`timescale 1ns/100ps
`include "decode_macros.svh"

module disp_imm_extract (
    input  logic [`TAIL_BYTES*8-1:0] tail,        // starts at the SIB slot
    input  decode_pkg::addr_t        addr,
    input  decode_pkg::imm_kind_e    imm_kind,
    input  logic                     opsize_ovr,
    output logic [`DISP_W-1:0]       disp,
    output logic [`IMM_W-1:0]        imm,
    output logic [2:0]               imm_len      // bytes of immediate
);
    import decode_pkg::*;

    localparam int TW = `TAIL_BYTES*8;

    logic [2:0]  imm_off;   // sib + displacement bytes
    logic [31:0] disp_raw;
    logic [31:0] imm_raw;

    // four bytes at a byte offset, little-endian
    function automatic logic [31:0] le_word(input logic [TW-1:0] bytes,
                                            input logic [2:0]    off);
        logic [TW-1:0] sh;
        sh = bytes << {off, 3'b000};
        return {sh[TW-25 -: 8], sh[TW-17 -: 8], sh[TW-9 -: 8], sh[TW-1 -: 8]};
    endfunction

    assign imm_off  = {2'b00, addr.has_sib} + addr.disp_bytes;
    assign disp_raw = le_word(tail, {2'b00, addr.has_sib});
    assign imm_raw  = le_word(tail, imm_off);

    ////////////////////////////////////////////////////////////
    // size select and sign extension
    ////////////////////////////////////////////////////////////
    always_comb begin
        case (imm_kind)
            IMM_BYTE: imm_len = 3'd1;
            IMM_WD:   imm_len = opsize_ovr ? 3'd2 : 3'd4;  // 66 gives a word
            default:  imm_len = 3'd0;
        endcase
    end

    always_comb begin
        case (addr.disp_bytes)
            3'd1:    disp = {{24{disp_raw[7]}}, disp_raw[7:0]};
            3'd4:    disp = disp_raw;
            default: disp = '0;
        endcase
        case (imm_len)
            3'd1:    imm = {{24{imm_raw[7]}}, imm_raw[7:0]};
            3'd2:    imm = {{16{imm_raw[15]}}, imm_raw[15:0]};
            3'd4:    imm = imm_raw;
            default: imm = '0;
        endcase
    end

endmodule

//--- rtl/eip_track.sv
`timescale 1ns/100ps
`include "decode_macros.svh"

module eip_track (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              redir_valid,
    input  logic              redir_init,   // 1 init, 0 resteer
    input  logic [`EIP_W-1:0] redir_eip,
    input  logic              advance,      // instruction accepted this edge
    input  logic [`LEN_W-1:0] length,
    output logic [`EIP_W-1:0] eip
);
    logic [`EIP_W-1:0] step;   // pointer past the current instruction

    assign step = eip + {{(`EIP_W-`LEN_W){1'b0}}, length};

    ////////////////////////////////////////////////////////////
    // pointer register
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            eip <= '0;
        end else if (redir_valid) begin
            eip <= redir_eip;     // init and resteer share the target bus
        end else if (advance) begin
            eip <= step;
        end
    end

endmodule

//--- rtl/decode_stage.sv
`timescale 1ns/100ps

module decode_stage #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     in_valid,
    output logic     in_ready,
    input  payload_t in_data,
    output logic     out_valid,
    input  logic     out_ready,
    output payload_t out_data
);
    // room when empty or when the held item leaves this cycle
    assign in_ready = ~out_valid | out_ready;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else if (in_ready) begin
            out_valid <= in_valid;
        end
    end

    // payload only moves on a transfer
    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            out_data <= in_data;
        end
    end

endmodule

//--- rtl/decode_top.sv
`timescale 1ns/100ps
`include "decode_macros.svh"

module decode_top (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 in_valid,
    output logic                 in_ready,
    input  logic [`PKT_W-1:0]    pkt,          // byte 0 in the top bits
    input  logic                 redir_valid,
    input  logic                 redir_init,   // 1 init, 0 resteer
    input  logic [`EIP_W-1:0]    redir_eip,
    output logic                 out_valid,
    input  logic                 out_ready,
    output decode_pkg::decoded_t out_data
);
    import decode_pkg::*;

    prefix_t            pfx;
    logic [1:0]         op_index;
    op_class_t          cls;
    addr_t              addr;
    logic [15:0]        modrm_bytes;
    logic [`DISP_W-1:0] disp;
    logic [`IMM_W-1:0]  imm;
    logic [2:0]         imm_len;
    logic [`PKT_W-1:0]  at_op;        // opcode moved up to byte 0
    logic [`PKT_W-1:0]  at_tail;      // first byte past opcode/ModRM on top
    logic [2:0]         tail_start;   // opcode plus ModRM bytes
    len_t               len;
    eip_t               eip;
    decoded_t           dec;
    logic               stage_valid;
    logic               stage_ready;
    logic               accept;

    ////////////////////////////////////////////////////////////
    // prefix and opcode
    ////////////////////////////////////////////////////////////
    prefix_decode u_pfx (
        .pkt_head (pkt[`PKT_W-1 -: `MAX_PFX*8]),
        .pfx      (pfx),
        .op_index (op_index)
    );

    assign at_op = pkt << {op_index, 3'b000};

    opcode_class u_opc (
        .op_bytes (at_op[`PKT_W-1 -: 16]),
        .cls      (cls)
    );

    ////////////////////////////////////////////////////////////
    // addressing, displacement, immediate
    ////////////////////////////////////////////////////////////
    assign modrm_bytes = cls.two_byte ? at_op[`PKT_W-17 -: 16] : at_op[`PKT_W-9 -: 16];

    modrm_decode u_modrm (
        .modrm_bytes (modrm_bytes),
        .has_modrm   (cls.has_modrm),
        .addr        (addr)
    );

    assign tail_start = 3'd1 + {2'b00, cls.two_byte} + {2'b00, cls.has_modrm};
    assign at_tail    = at_op << {tail_start, 3'b000};

    disp_imm_extract u_dimm (
        .tail       (at_tail[`PKT_W-1 -: `TAIL_BYTES*8]),
        .addr       (addr),
        .imm_kind   (cls.imm_kind),
        .opsize_ovr (pfx.opsize),
        .disp       (disp),
        .imm        (imm),
        .imm_len    (imm_len)
    );

    // prefixes + opcode/ModRM + SIB + displacement + immediate
    assign len = len_t'(pfx.count) + len_t'(tail_start) + len_t'(addr.has_sib)
               + len_t'(addr.disp_bytes) + len_t'(imm_len);

    ////////////////////////////////////////////////////////////
    // pointer and output stage
    ////////////////////////////////////////////////////////////
    assign accept = in_valid & in_ready;

    eip_track u_eip (
        .clk         (clk),
        .rst_n       (rst_n),
        .redir_valid (redir_valid),
        .redir_init  (redir_init),
        .redir_eip   (redir_eip),
        .advance     (accept),
        .length      (len),
        .eip         (eip)
    );

    always_comb begin
        dec.pfx      = pfx;
        dec.opcode   = cls.two_byte ? at_op[`PKT_W-9 -: 8] : at_op[`PKT_W-1 -: 8];
        dec.cls      = cls;
        dec.addr     = addr;
        dec.disp     = disp;
        dec.imm      = imm;
        dec.len      = len;
        dec.eip      = eip;
        dec.next_eip = eip + eip_t'(len);
    end

    // redirect blocks the packet for this cycle
    assign stage_valid = in_valid & ~redir_valid;
    assign in_ready    = stage_ready & ~redir_valid;

    decode_stage #(
        .payload_t (decoded_t)
    ) u_stage (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (stage_valid),
        .in_ready  (stage_ready),
        .in_data   (dec),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_data  (out_data)
    );

endmodule

//--- verif/decode_tb.sv
`timescale 1ns/100ps
`include "decode_macros.svh"

module decode_tb;
    import decode_pkg::*;

    localparam int WAIT_LIMIT = 50;   // cycles per wait loop

    logic              clk;
    logic              rst_n;
    logic              in_valid;
    logic              in_ready;
    logic [`PKT_W-1:0] pkt;
    logic              redir_valid;
    logic              redir_init;
    logic [`EIP_W-1:0] redir_eip;
    logic              out_valid;
    logic              out_ready;
    decoded_t          out_data;

    int seed   = 5406;
    int errors = 0;
    int failed = 0;

    // one entry per line of the cases file
    string             name_q[$];
    int                rd_q[$];
    logic [31:0]       reip_q[$];
    logic [`PKT_W-1:0] pkt_q[$];
    len_t              len_q[$];
    prefix_t           pfx_q[$];
    op_class_t         cls_q[$];
    logic [31:0]       disp_q[$];
    logic [31:0]       imm_q[$];
    logic [31:0]       eip_q[$];

    decode_top dut0 (
        .clk (clk), .rst_n (rst_n),
        .in_valid (in_valid), .in_ready (in_ready), .pkt (pkt),
        .redir_valid (redir_valid), .redir_init (redir_init), .redir_eip (redir_eip),
        .out_valid (out_valid), .out_ready (out_ready), .out_data (out_data)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;   // 20 ns period
    end

    ////////////////////////////////////////////////////////////
    // compare tasks
    ////////////////////////////////////////////////////////////
    task automatic check_len(input string name, input len_t exp, input len_t act);
        if (act !== exp) begin
            $display("FAIL %s len: expected %0d, actual %0d", name, exp, act);
            errors++;
        end
    endtask

    task automatic check_prefix(input string name, input prefix_t exp, input prefix_t act);
        if (act !== exp) begin
            $display("FAIL %s prefix: expected %h, actual %h", name, exp, act);
            errors++;
        end
    endtask

    task automatic check_class(input string name, input op_class_t exp, input op_class_t act);
        if (act !== exp) begin
            $display("FAIL %s class: expected %h, actual %h", name, exp, act);
            errors++;
        end
    endtask

    task automatic check_word(input string name, input string field,
                              input logic [31:0] exp, input logic [31:0] act);
        if (act !== exp) begin
            $display("FAIL %s %s: expected %h, actual %h", name, field, exp, act);
            errors++;
        end
    endtask

    ////////////////////////////////////////////////////////////
    // case file, lines starting with # skipped
    ////////////////////////////////////////////////////////////
    task automatic load_cases();
        int                fd;
        int                n;
        string             line;
        string             f_name;
        int                f_rd;
        logic [31:0]       f_reip;
        logic [`PKT_W-1:0] f_pkt;
        logic [3:0]        f_len;
        logic [6:0]        f_pfx;
        logic [4:0]        f_cls;
        logic [31:0]       f_disp;
        logic [31:0]       f_imm;
        logic [31:0]       f_eip;
        fd = $fopen("verif/decode_cases.txt", "r");
        if (fd == 0) begin
            $display("could not open verif/decode_cases.txt");
        end else begin
            while (!$feof(fd)) begin
                line = "";
                n    = $fgets(line, fd);
                if (n > 0 && line.getc(0) != "#") begin
                    n = $sscanf(line, "%s %d %h %h %d %h %h %h %h %h", f_name, f_rd, f_reip,
                                f_pkt, f_len, f_pfx, f_cls, f_disp, f_imm, f_eip);
                    if (n == 10) begin
                        name_q.push_back(f_name);
                        rd_q.push_back(f_rd);
                        reip_q.push_back(f_reip);
                        pkt_q.push_back(f_pkt);
                        len_q.push_back(len_t'(f_len));
                        pfx_q.push_back(prefix_t'(f_pfx));
                        cls_q.push_back(op_class_t'(f_cls));
                        disp_q.push_back(f_disp);
                        imm_q.push_back(f_imm);
                        eip_q.push_back(f_eip);
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // driver and monitor
    ////////////////////////////////////////////////////////////
    task automatic send_case(input int i);
        int waited;
        waited = 0;
        if (rd_q[i] != 0) begin            // redirect cycle, packet offered but held off
            @(negedge clk);
            in_valid    = 1'b1;
            pkt         = pkt_q[i];
            redir_valid = 1'b1;
            redir_init  = (rd_q[i] == 1);
            redir_eip   = reip_q[i];
        end
        @(negedge clk);
        redir_valid = 1'b0;
        in_valid    = 1'b1;
        pkt         = pkt_q[i];
        #5;                                // settle, then look at in_ready
        while (!in_ready && waited < WAIT_LIMIT) begin
            @(negedge clk);
            #5;
            waited++;
        end
        if (!in_ready) begin
            $display("timeout: packet for %s was never accepted", name_q[i]);
            errors++;
        end else begin
            @(posedge clk);                // accept edge
        end
    endtask

    task automatic take_output(input int i);
        int                waited;
        int                rnd;
        int                errs_before;
        int                op_at;
        logic              got;
        logic [`PKT_W-1:0] sent;
        logic [7:0]        exp_op;
        waited = 0;
        got    = 1'b0;
        while (!got && waited < WAIT_LIMIT) begin
            @(negedge clk);
            rnd       = $random(seed);
            out_ready = (rnd[1:0] != 2'b00);   // ready about 3 cycles in 4
            #5;
            got = out_valid & out_ready;
            waited++;
        end
        if (!got) begin
            $display("timeout: no output arrived for %s", name_q[i]);
            errors++;
            failed++;
        end else begin
            // opcode byte follows the prefixes, or the 0F escape
            op_at  = int'(pfx_q[i].count) + int'(cls_q[i].two_byte);
            sent   = pkt_q[i];
            exp_op = sent[`PKT_W-1-8*op_at -: 8];
            errs_before = errors;
            check_len(name_q[i], len_q[i], out_data.len);
            check_prefix(name_q[i], pfx_q[i], out_data.pfx);
            check_class(name_q[i], cls_q[i], out_data.cls);
            check_word(name_q[i], "opcode", {24'h0, exp_op}, {24'h0, out_data.opcode});
            check_word(name_q[i], "disp", disp_q[i], out_data.disp);
            check_word(name_q[i], "imm", imm_q[i], out_data.imm);
            check_word(name_q[i], "eip", eip_q[i], out_data.eip);
            check_word(name_q[i], "next_eip", eip_q[i] + 32'(len_q[i]), out_data.next_eip);
            if (errors == errs_before) begin
                $display("ok   %s", name_q[i]);
            end else begin
                failed++;
            end
        end
    endtask

    initial begin
        rst_n       = 1'b0;
        in_valid    = 1'b0;
        pkt         = '0;
        redir_valid = 1'b0;
        redir_init  = 1'b0;
        redir_eip   = '0;
        out_ready   = 1'b0;
        load_cases();
        if (name_q.size() == 0) begin
            $display("no test cases found in the cases file");
            errors++;
        end else begin
            repeat (3) @(negedge clk);   // 3 reset cycles
            rst_n = 1'b1;
            fork
                begin
                    for (int i = 0; i < name_q.size(); i++) send_case(i);
                    @(negedge clk);
                    in_valid = 1'b0;
                end
                begin
                    for (int i = 0; i < name_q.size(); i++) take_output(i);
                end
            join
            @(negedge clk);
            out_ready = 1'b1;
            #5;
            if (out_valid) begin          // each case exactly once
                $display("an extra output appeared after the last test");
                errors++;
            end
        end
        $display("tests: %0d run, %0d passed, %0d failed, %0d mismatches",
                 name_q.size(), name_q.size() - failed, failed, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

//--- all.f
+incdir+rtl
rtl/decode_pkg.sv
rtl/prefix_decode.sv
rtl/opcode_class.sv
rtl/modrm_decode.sv
rtl/disp_imm_extract.sv
rtl/eip_track.sv
rtl/decode_stage.sv
rtl/decode_top.sv
verif/decode_tb.sv

//--- run.sh
#!/bin/sh
# build and run the decode testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD=obj_dir
LOG=sim.log

verilator --binary --timing -Wno-fatal --top-module decode_tb \
    -Mdir "$BUILD" -o decode_sim -f all.f
if [ $? -ne 0 ]; then
    echo "verilator compile failed"
    exit 1
fi

"./$BUILD/decode_sim" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^Done: no errors$" "$LOG"; then
    exit 0
fi
echo "pass message not found in $LOG"
exit 1

//--- verif/decode_cases.txt
# name rd reip pkt len pfx cls disp imm eip   (rd: 0 none, 1 init, 2 resteer; len decimal)
# pfx = {count[1:0],rep,opsize,seg[2:0]}  cls = {two_byte,has_modrm,imm_kind[1:0],invalid}
nop             1 00001000 90000000000000000000000000000000 1 00 00 00000000 00000000 00001000
add_eax_id      0 00000000 05785634120000000000000000000000 5 00 04 00000000 12345678 00001001
mov_r_r         0 00000000 8bc10000000000000000000000000000 2 00 08 00000000 00000000 00001006
jcc_rel32       0 00000000 0f841000000000000000000000000000 6 00 14 00000000 00000010 00001008
three_prefix    0 00000000 f3662e05341200000000000000000000 6 7a 04 00000000 00001234 0000100e
sib_disp32      0 00000000 8b842478563412000000000000000000 7 00 08 12345678 00000000 00001014
disp8_imm8      0 00000000 8345f8ff000000000000000000000000 4 00 0a fffffff8 ffffffff 0000101b
unknown_hlt     0 00000000 f4000000000000000000000000000000 1 00 01 00000000 00000000 0000101f
unknown_pfx     0 00000000 66f40000000000000000000000000000 2 28 01 00000000 00000000 00001020
call_rel32      2 00400000 e8000100000000000000000000000000 5 00 04 00000000 00000100 00400000
jmp_rel8        0 00000000 ebfe0000000000000000000000000000 2 00 02 00000000 fffffffe 00400005
mov_r_imm       0 00000000 b8efbeadde0000000000000000000000 5 00 04 00000000 deadbeef 00400007
gs_abs_store    0 00000000 65890500200000000000000000000000 7 26 08 00002000 00000000 0040000c
sib_no_base     0 00000000 8b042500100000000000000000000000 7 00 08 00001000 00000000 00400013
imul_r_r        0 00000000 0fafc300000000000000000000000000 3 00 18 00000000 00000000 0040001a
add_rm_id       0 00000000 81c04433221100000000000000000000 6 00 0c 00000000 11223344 0040001d
add_rm_iw       0 00000000 6681c000800000000000000000000000 5 28 0c 00000000 ffff8000 00400023
ret             0 00000000 c3000000000000000000000000000000 1 00 00 00000000 00000000 00400028
add_al_ib       1 00008000 047f0000000000000000000000000000 2 00 02 00000000 0000007f 00008000
seg_last_wins   0 00000000 263e9000000000000000000000000000 3 44 00 00000000 00000000 00008002
